/* Makefile */
TOP := tb_rv_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* common/rv_pkg.sv */
// shared widths, encodings and decode enums for the rv32i execution slice
// every rtl file refers to these by scoped name
package rv_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  // data and instruction width
  localparam int XLEN = 32;

  // register index width and register count
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS = 32;

  // funct7 value that selects sub and sra
  localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

  ////////////////////////////////////////////////////////////////////////////
  // major opcodes
  ////////////////////////////////////////////////////////////////////////////

  // only the integer compute groups are kept
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  ////////////////////////////////////////////////////////////////////////////
  // decoded control
  ////////////////////////////////////////////////////////////////////////////

  // alu function
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // operand a source
  // zero is used by lui so the alu just passes the immediate
  typedef enum logic [1:0] {
    OPA_RS1  = 2'd0,
    OPA_PC   = 2'd1,
    OPA_ZERO = 2'd2
  } op_a_sel_e;

  // operand b source
  typedef enum logic {
    OPB_RS2 = 1'b0,
    OPB_IMM = 1'b1
  } op_b_sel_e;

endpackage

/* decode/rv_decoder.sv */
// combinational rv32i decoder for the lui, auipc, op-imm and op groups
// turns one instruction word into alu control, an immediate and register indices
module rv_decoder (
  input  logic [rv_pkg::XLEN-1:0]       instr_i,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rd_addr_o,
  output rv_pkg::alu_op_e               alu_op_o,
  output rv_pkg::op_a_sel_e             op_a_sel_o,
  output rv_pkg::op_b_sel_e             op_b_sel_o,
  output logic [rv_pkg::XLEN-1:0]       imm_o,
  output logic                          rd_we_o,
  output logic                          illegal_o
);

  // funct3 codes shared by op-imm and op
  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101,
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } funct3_e;

  rv_pkg::opcode_e          opcode;
  funct3_e                  funct3;
  logic [6:0]               funct7;
  logic [rv_pkg::XLEN-1:0]  i_imm;
  logic [rv_pkg::XLEN-1:0]  u_imm;
  logic [rv_pkg::XLEN-1:0]  shamt_imm;
  rv_pkg::alu_op_e          base_op;
  logic                     legal;

  ////////////////////////////////////////////////////////////////////////////
  // fields and immediates
  ////////////////////////////////////////////////////////////////////////////

  assign opcode     = rv_pkg::opcode_e'(instr_i[6:0]);
  assign funct3     = funct3_e'(instr_i[14:12]);
  assign funct7     = instr_i[31:25];
  assign rd_addr_o  = instr_i[11:7];
  assign rs1_addr_o = instr_i[19:15];
  assign rs2_addr_o = instr_i[24:20];

  assign i_imm      = {{20{instr_i[31]}}, instr_i[31:20]};
  assign u_imm      = {instr_i[31:12], 12'b0};
  assign shamt_imm  = {27'b0, instr_i[24:20]};

  // alu function implied by funct3 alone
  always_comb begin
    base_op = rv_pkg::ALU_ADD;
    case (funct3)
      F3_ADD:  base_op = rv_pkg::ALU_ADD;
      F3_SLL:  base_op = rv_pkg::ALU_SLL;
      F3_SLT:  base_op = rv_pkg::ALU_SLT;
      F3_SLTU: base_op = rv_pkg::ALU_SLTU;
      F3_XOR:  base_op = rv_pkg::ALU_XOR;
      F3_SR:   base_op = rv_pkg::ALU_SRL;
      F3_OR:   base_op = rv_pkg::ALU_OR;
      F3_AND:  base_op = rv_pkg::ALU_AND;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // opcode match
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    alu_op_o   = base_op;
    op_a_sel_o = rv_pkg::OPA_RS1;
    op_b_sel_o = rv_pkg::OPB_IMM;
    imm_o      = i_imm;
    legal      = 1'b1;
    case (opcode)
      rv_pkg::OPC_LUI: begin
        alu_op_o   = rv_pkg::ALU_ADD;
        op_a_sel_o = rv_pkg::OPA_ZERO;
        imm_o      = u_imm;
      end
      rv_pkg::OPC_AUIPC: begin
        alu_op_o   = rv_pkg::ALU_ADD;
        op_a_sel_o = rv_pkg::OPA_PC;
        imm_o      = u_imm;
      end
      rv_pkg::OPC_OP_IMM: begin
        // shifts carry shamt in the low immediate bits, funct7 above it
        if (funct3 == F3_SLL) begin
          imm_o = shamt_imm;
          legal = (funct7 == 7'b0);
        end else if (funct3 == F3_SR) begin
          imm_o = shamt_imm;
          if (funct7 == rv_pkg::FUNCT7_ALT) begin
            alu_op_o = rv_pkg::ALU_SRA;
          end else begin
            legal = (funct7 == 7'b0);
          end
        end
      end
      rv_pkg::OPC_OP: begin
        op_b_sel_o = rv_pkg::OPB_RS2;
        if (funct7 == rv_pkg::FUNCT7_ALT) begin
          // only add and srl have an alternate form
          if (funct3 == F3_ADD) begin
            alu_op_o = rv_pkg::ALU_SUB;
          end else if (funct3 == F3_SR) begin
            alu_op_o = rv_pkg::ALU_SRA;
          end else begin
            legal = 1'b0;
          end
        end else if (funct7 != 7'b0) begin
          legal = 1'b0;
        end
      end
      default: legal = 1'b0;
    endcase
  end

  // x0 writes are dropped here and nowhere else
  assign rd_we_o   = legal && (rd_addr_o != '0);
  assign illegal_o = !legal;

endmodule

/* execute/rv_execute.sv */
// operand select, alu and the write-back register
// results appear one cycle after the instruction strobe
module rv_execute (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          instr_valid_i,
  input  logic [rv_pkg::XLEN-1:0]       pc_i,
  input  rv_pkg::alu_op_e               alu_op_i,
  input  rv_pkg::op_a_sel_e             op_a_sel_i,
  input  rv_pkg::op_b_sel_e             op_b_sel_i,
  input  logic [rv_pkg::XLEN-1:0]       imm_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rd_addr_i,
  input  logic                          rd_we_i,
  input  logic                          illegal_i,
  input  logic [rv_pkg::XLEN-1:0]       rs1_data_i,
  input  logic [rv_pkg::XLEN-1:0]       rs2_data_i,
  output logic                          wb_we_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] wb_addr_o,
  output logic [rv_pkg::XLEN-1:0]       wb_data_o,
  output logic                          illegal_o
);

  logic [rv_pkg::XLEN-1:0] op_a;
  logic [rv_pkg::XLEN-1:0] op_b;
  logic [4:0]              shamt;
  logic [rv_pkg::XLEN-1:0] alu_result;
  logic                    wb_fire;

  always_comb begin
    case (op_a_sel_i)
      rv_pkg::OPA_RS1: op_a = rs1_data_i;
      rv_pkg::OPA_PC:  op_a = pc_i;
      default:         op_a = '0;
    endcase
  end

  assign op_b  = (op_b_sel_i == rv_pkg::OPB_IMM) ? imm_i : rs2_data_i;
  assign shamt = op_b[4:0];

  ////////////////////////////////////////////////////////////////////////////
  // alu
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_op_i)
      rv_pkg::ALU_ADD:  alu_result = op_a + op_b;
      rv_pkg::ALU_SUB:  alu_result = op_a - op_b;
      rv_pkg::ALU_SLL:  alu_result = op_a << shamt;
      rv_pkg::ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      rv_pkg::ALU_SLTU: alu_result = {31'b0, op_a < op_b};
      rv_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
      rv_pkg::ALU_SRL:  alu_result = op_a >> shamt;
      rv_pkg::ALU_SRA:  alu_result = $unsigned($signed(op_a) >>> shamt);
      rv_pkg::ALU_OR:   alu_result = op_a | op_b;
      rv_pkg::ALU_AND:  alu_result = op_a & op_b;
      default:          alu_result = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // write-back stage
  ////////////////////////////////////////////////////////////////////////////

  assign wb_fire = instr_valid_i && rd_we_i;

  // address and data hold the last real write-back between strobes
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb_we_o   <= 1'b0;
      illegal_o <= 1'b0;
      wb_addr_o <= '0;
      wb_data_o <= '0;
    end else begin
      wb_we_o   <= wb_fire;
      illegal_o <= instr_valid_i && illegal_i;
      if (wb_fire) begin
        wb_addr_o <= rd_addr_i;
        wb_data_o <= alu_result;
      end
    end
  end

endmodule

/* logic/rv_core_top.sv */
// rv32i execution slice top, decode and register read in one cycle
// write-back and illegal strobes follow one cycle after instr_valid_i
module rv_core_top (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          instr_valid_i,
  input  logic [rv_pkg::XLEN-1:0]       instr_i,
  input  logic [rv_pkg::XLEN-1:0]       pc_i,
  output logic                          rd_we_o,
  output logic [rv_pkg::REG_ADDR_W-1:0] rd_addr_o,
  output logic [rv_pkg::XLEN-1:0]       rd_data_o,
  output logic                          illegal_o
);

  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr;
  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr;
  logic [rv_pkg::REG_ADDR_W-1:0] rd_addr;
  rv_pkg::alu_op_e               alu_op;
  rv_pkg::op_a_sel_e             op_a_sel;
  rv_pkg::op_b_sel_e             op_b_sel;
  logic [rv_pkg::XLEN-1:0]       imm;
  logic                          rd_we;
  logic                          illegal;
  logic [rv_pkg::XLEN-1:0]       rs1_data;
  logic [rv_pkg::XLEN-1:0]       rs2_data;

  rv_decoder rv_decoder_inst (
    .instr_i    (instr_i),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr),
    .rd_addr_o  (rd_addr),
    .alu_op_o   (alu_op),
    .op_a_sel_o (op_a_sel),
    .op_b_sel_o (op_b_sel),
    .imm_o      (imm),
    .rd_we_o    (rd_we),
    .illegal_o  (illegal)
  );

  rv_execute rv_execute_inst (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .pc_i          (pc_i),
    .alu_op_i      (alu_op),
    .op_a_sel_i    (op_a_sel),
    .op_b_sel_i    (op_b_sel),
    .imm_i         (imm),
    .rd_addr_i     (rd_addr),
    .rd_we_i       (rd_we),
    .illegal_i     (illegal),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .wb_we_o       (rd_we_o),
    .wb_addr_o     (rd_addr_o),
    .wb_data_o     (rd_data_o),
    .illegal_o     (illegal_o)
  );

  // write port is fed straight from the write-back register
  rv_regfile rv_regfile_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .wb_we_i    (rd_we_o),
    .wb_addr_i  (rd_addr_o),
    .wb_data_i  (rd_data_o),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

endmodule

/* result/rv_regfile.sv */
// integer register file, two combinational read ports and one write port
// a pending write-back is forwarded to any read port that asks for it
module rv_regfile (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr_i,
  input  logic                          wb_we_i,
  input  logic [rv_pkg::REG_ADDR_W-1:0] wb_addr_i,
  input  logic [rv_pkg::XLEN-1:0]       wb_data_i,
  output logic [rv_pkg::XLEN-1:0]       rs1_data_o,
  output logic [rv_pkg::XLEN-1:0]       rs2_data_o
);

  logic [rv_pkg::XLEN-1:0] regs [rv_pkg::NUM_REGS];
  logic                    rs1_hit;
  logic                    rs2_hit;

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  // x0 is never addressed by a write, so it keeps its reset value
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we_i) begin
      regs[wb_addr_i] <= wb_data_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // read with bypass
  ////////////////////////////////////////////////////////////////////////////

  // the write lands at the next edge, too late for the instruction behind it
  assign rs1_hit = wb_we_i && (wb_addr_i == rs1_addr_i);
  assign rs2_hit = wb_we_i && (wb_addr_i == rs2_addr_i);

  assign rs1_data_o = rs1_hit ? wb_data_i : regs[rs1_addr_i];
  assign rs2_data_o = rs2_hit ? wb_data_i : regs[rs2_addr_i];

endmodule

/* src.f */
common/rv_pkg.sv
decode/rv_decoder.sv
execute/rv_execute.sv
result/rv_regfile.sv
logic/rv_core_top.sv
testbench/rv_core_assertions.sv
testbench/tb_rv_core.sv

/* testbench/rv_core_assertions.sv */
// concurrent checks on the write-back and illegal strobes of the core top
// attached to rv_core_top with bind from the testbench
module rv_core_assertions (
  input logic                          clk_i,
  input logic                          arst_n_i,
  input logic                          instr_valid_i,
  input logic                          rd_we_i,
  input logic [rv_pkg::REG_ADDR_W-1:0] rd_addr_i,
  input logic                          illegal_i
);

  // one instruction gives a write-back or an illegal flag, never both
  strobes_exclusive: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) !(rd_we_i && illegal_i)
  ) else $error("write-back and illegal strobes high in the same cycle");

  no_x0_write: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) rd_we_i |-> (rd_addr_i != '0)
  ) else $error("write-back addressed to x0");

  // strobes only follow an accepted instruction
  strobe_follows_valid: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) (rd_we_i || illegal_i) |-> $past(instr_valid_i)
  ) else $error("strobe without an instruction in the previous cycle");

endmodule

/* testbench/tb_rv_core.sv */
// random-stimulus testbench for the rv32i execution slice
// a register model here predicts every write-back and illegal strobe
module tb_rv_core;

  logic        clk;
  logic        arst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] pc;
  logic        rd_we;
  logic [4:0]  rd_addr;
  logic [31:0] rd_data;
  logic        illegal;

  logic [31:0] model_regs [32];
  logic        exp_we;
  logic        exp_ill;
  logic [4:0]  exp_addr;
  logic [31:0] exp_data;
  integer      seed;
  int          errors;
  int          checks;
  int          tests_run;
  int          tests_failed;
  int          test_start_errors;

  rv_core_top rv_core_top_inst (
    .clk_i         (clk),
    .arst_n_i      (arst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .pc_i          (pc),
    .rd_we_o       (rd_we),
    .rd_addr_o     (rd_addr),
    .rd_data_o     (rd_data),
    .illegal_o     (illegal)
  );

  bind rv_core_top rv_core_assertions rv_core_assertions_inst (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .rd_we_i       (rd_we_o),
    .rd_addr_i     (rd_addr_o),
    .illegal_i     (illegal_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  // alt selects sub and sra
  function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                          input logic [31:0] a, input logic [31:0] b);
    logic signed [31:0] sa;
    sa = a;
    case (f3)
      3'd0: ref_alu = alt ? a - b : a + b;
      3'd1: ref_alu = a << b[4:0];
      3'd2: ref_alu = {31'b0, $signed(a) < $signed(b)};
      3'd3: ref_alu = {31'b0, a < b};
      3'd4: ref_alu = a ^ b;
      3'd5: begin
        if (alt) ref_alu = sa >>> b[4:0];
        else ref_alu = a >> b[4:0];
      end
      3'd6: ref_alu = a | b;
      default: ref_alu = a & b;
    endcase
  endfunction

  task automatic check_outputs();
    checks++;
    assert (rd_we === exp_we) else begin
      $display("mismatch rd_we_o: got %h, expected %h", rd_we, exp_we);
      errors++;
    end
    assert (illegal === exp_ill) else begin
      $display("mismatch illegal_o: got %h, expected %h", illegal, exp_ill);
      errors++;
    end
    assert (rd_addr === exp_addr) else begin
      $display("mismatch rd_addr_o: got %h, expected %h", rd_addr, exp_addr);
      errors++;
    end
    assert (rd_data === exp_data) else begin
      $display("mismatch rd_data_o: got %h, expected %h", rd_data, exp_data);
      errors++;
    end
  endtask

  // check the last prediction, drive the next word and predict it
  task automatic issue(input logic valid, input logic [31:0] word, input logic [31:0] pc_val,
                       input logic legal, input logic [4:0] rd, input logic [31:0] result);
    @(posedge clk);
    #1;
    check_outputs();
    instr_valid = valid;
    instr = word;
    pc = pc_val;
    exp_we = valid && legal && (rd != 5'd0);
    exp_ill = valid && !legal;
    // registers update at once, as the bypass makes them visible
    if (exp_we) begin
      exp_addr = rd;
      exp_data = result;
      model_regs[rd] = result;
    end
  endtask

  task automatic reg_op(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                        input logic [4:0] rs1, input logic [4:0] rs2);
    logic [31:0] word;
    word = {alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, 7'b0110011};
    issue(1'b1, word, rand32(), 1'b1, rd,
          ref_alu(f3, alt, model_regs[rs1], model_regs[rs2]));
  endtask

  task automatic imm_op(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                        input logic [11:0] imm);
    logic [31:0] word;
    word = {imm, rs1, f3, rd, 7'b0010011};
    issue(1'b1, word, rand32(), 1'b1, rd,
          ref_alu(f3, (f3 == 3'd5) && imm[10], model_regs[rs1], {{20{imm[11]}}, imm}));
  endtask

  task automatic upper_op(input logic auipc, input logic [4:0] rd, input logic [19:0] imm);
    logic [31:0] word;
    logic [31:0] pc_val;
    pc_val = rand32();
    word = {imm, rd, auipc ? 7'b0010111 : 7'b0110111};
    issue(1'b1, word, pc_val, 1'b1, rd, (auipc ? pc_val : 32'd0) + {imm, 12'b0});
  endtask

  task automatic idle_cycle();
    issue(1'b0, rand32(), rand32(), 1'b1, 5'd0, 32'd0);
  endtask

  function automatic logic [31:0] random_illegal_word();
    logic [31:0] w;
    logic [31:0] pick;
    w = rand32();
    pick = rand32();
    case (pick[1:0])
      2'd0: begin
        // loads, stores, branches, jumps, system, fence, op-32
        case (pick[4:2])
          3'd0: w[6:0] = 7'b0000011;
          3'd1: w[6:0] = 7'b0100011;
          3'd2: w[6:0] = 7'b1100011;
          3'd3: w[6:0] = 7'b1101111;
          3'd4: w[6:0] = 7'b1100111;
          3'd5: w[6:0] = 7'b1110011;
          3'd6: w[6:0] = 7'b0001111;
          default: w[6:0] = 7'b0111011;
        endcase
      end
      2'd1: begin
        w[31:25] = 7'b0000001;
        w[6:0] = 7'b0110011;
      end
      2'd2: begin
        // alternate funct7 on a funct3 with no alternate form
        w[31:25] = 7'b0100000;
        w[6:0] = 7'b0110011;
        if (w[14:12] == 3'd0 || w[14:12] == 3'd5) w[13] = 1'b1;
      end
      default: begin
        w[31:25] = 7'b0100000;
        w[14:12] = 3'b001;
        w[6:0] = 7'b0010011;
      end
    endcase
    random_illegal_word = w;
  endfunction

  task automatic begin_test();
    test_start_errors = errors;
  endtask

  task automatic end_test(input string name);
    idle_cycle();
    tests_run++;
    if (errors == test_start_errors) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - test_start_errors);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int          wait_cycles;
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  prev_rd;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    seed = 32'hc6a1;
    errors = 0;
    checks = 0;
    tests_run = 0;
    tests_failed = 0;
    arst_n = 1'b1;
    instr_valid = 1'b0;
    instr = '0;
    pc = '0;
    exp_we = 1'b0;
    exp_ill = 1'b0;
    exp_addr = '0;
    exp_data = '0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;

    begin_test();
    #2;
    arst_n = 1'b0;
    repeat (5) begin
      @(posedge clk);
      #1;
      check_outputs();
    end
    arst_n = 1'b1;
    wait_cycles = 0;
    while ((rd_we !== 1'b0 || illegal !== 1'b0) && wait_cycles < 20) begin
      @(posedge clk);
      #1;
      wait_cycles++;
    end

    if (wait_cycles >= 20) begin
      errors++;
      tests_failed++;
      $display("test reset: strobes did not settle low within 20 cycles of reset release");
    end else begin
      // every source register reads zero straight after reset
      for (int i = 1; i < 32; i++) reg_op(3'd6, 1'b0, i[4:0], i[4:0], 5'(32 - i));
      end_test("reset");

      begin_test();
      for (int i = 1; i < 32; i++) begin
        r = rand32();
        upper_op(1'b0, i[4:0], r[31:12]);
        r = rand32();
        imm_op(3'd0, i[4:0], i[4:0], r[11:0]);
      end
      repeat (40) begin
        r = rand32();
        upper_op(r[0], r[11:7], r[31:12]);
      end
      end_test("lui and auipc");

      begin_test();
      prev_rd = 5'd1;
      for (int i = 0; i < 300; i++) begin
        r = rand32();
        f3 = r[2:0];
        rd = r[7:3];
        alt = r[8] && (f3 == 3'd0 || f3 == 3'd5);
        // odd ops read the register written just before
        if (i % 2 == 1) begin
          reg_op(f3, alt, rd, r[21] ? prev_rd : r[18:14], r[21] ? r[13:9] : prev_rd);
        end else begin
          reg_op(f3, alt, rd, r[18:14], r[13:9]);
        end
        prev_rd = rd;
        if (i % 2 == 1 && r[20:19] == 2'd0) idle_cycle();
      end
      end_test("register alu ops");

      begin_test();
      for (int i = 0; i < 300; i++) begin
        r = rand32();
        f3 = r[2:0];
        imm = r[31:20];
        if (f3 == 3'd1) imm[11:5] = 7'b0;
        else if (f3 == 3'd5) imm[11:5] = r[8] ? 7'b0100000 : 7'b0;
        imm_op(f3, r[7:3], (i % 2 == 1) ? prev_rd : r[13:9], imm);
        prev_rd = r[7:3];
        if (i % 2 == 1 && r[15:14] == 2'd0) idle_cycle();
      end
      // sltiu against negative immediates
      for (int i = 1; i < 8; i++) imm_op(3'd3, i[4:0], 5'(i + 8), 12'(-i));
      end_test("immediate alu ops");

      begin_test();
      for (int i = 0; i < 20; i++) begin
        r = rand32();
        imm_op(3'd0, 5'd0, r[4:0], r[31:20]);
        reg_op(r[7:5], 1'b0, 5'd0, r[12:8], r[17:13]);
        upper_op(r[23], 5'd0, r[31:12]);
        reg_op(3'd6, 1'b0, r[22:18] | 5'd1, 5'd0, 5'd0);
      end
      end_test("x0 handling");

      begin_test();
      for (int i = 0; i < 200; i++) begin
        r = rand32();
        case (r[1:0])
          2'd0: send_illegal();
          2'd1: idle_cycle();
          default: reg_op(r[4:2], 1'b0, r[9:5], r[14:10], r[19:15]);
        endcase
      end
      end_test("illegal words and idle cycles");
    end

    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  task automatic send_illegal();
    issue(1'b1, random_illegal_word(), rand32(), 1'b0, 5'd0, 32'd0);
  endtask

endmodule
